/* rtl/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ---------------------------------------------------------------------------
// Memory word geometry
// ---------------------------------------------------------------------------

// Data and address width
`define MEM_WORD_W 32

// One strobe per byte lane
`define MEM_STRB_W 4

// Byte offset inside a word
`define MEM_OFS_W 2

`endif

/* rtl/mips_isa_pkg.sv */
package mips_isa_pkg;

    // ---------------------------------------------------------------------------
    // Memory instruction opcodes as decoded by the core
    // ---------------------------------------------------------------------------
    typedef enum logic [6:0] {
        LB  = 7'd42,
        LBU = 7'd43,
        LH  = 7'd44,
        LHU = 7'd45,
        LW  = 7'd47,
        LWL = 7'd48,
        LWR = 7'd49,
        SB  = 7'd50,
        SH  = 7'd51,
        SW  = 7'd52
    } mem_op_t;

    // What the core wants from memory this time
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_FETCH = 2'd1,
        ACC_LOAD  = 2'd2,
        ACC_STORE = 2'd3
    } access_kind_t;

endpackage

/* rtl/mem_bus_pkg.sv */
`include "mem_defs.svh"

package mem_bus_pkg;

    // ---------------------------------------------------------------------------
    // Core side
    // ---------------------------------------------------------------------------

    // Addr is the PC on a fetch and the ALU result otherwise
    typedef struct packed {
        mips_isa_pkg::access_kind_t kind;
        mips_isa_pkg::mem_op_t      op;
        logic [`MEM_WORD_W-1:0]     addr;
        logic [`MEM_WORD_W-1:0]     reg_b;
    } core_req_t;

    typedef struct packed {
        logic                   done;
        logic [`MEM_WORD_W-1:0] rdata;
    } core_resp_t;

    // ---------------------------------------------------------------------------
    // APB side
    // ---------------------------------------------------------------------------
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`MEM_WORD_W-1:0] paddr;
        logic [`MEM_WORD_W-1:0] pwdata;
        logic [`MEM_STRB_W-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                   pready;
        logic [`MEM_WORD_W-1:0] prdata;
    } apb_resp_t;

    // Transfer controller
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SETUP  = 2'd1,
        ST_ACCESS = 2'd2
    } ctrl_state_t;

endpackage

/* rtl/load_aligner.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module load_aligner (
    input  mem_bus_pkg::core_req_t  req,
    input  logic [`MEM_WORD_W-1:0]  word,
    output logic [`MEM_WORD_W-1:0]  rdata
);
    import mips_isa_pkg::*;

    logic [`MEM_OFS_W-1:0]  ofs;
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;
    logic [`MEM_WORD_W-1:0] lwl_data;
    logic [`MEM_WORD_W-1:0] lwr_data;

    assign ofs = req.addr[`MEM_OFS_W-1:0];

    // Big-endian lanes, offset 0 is the top byte
    always_comb begin
        case (ofs)
            2'd0:    sel_byte = word[31:24];
            2'd1:    sel_byte = word[23:16];
            2'd2:    sel_byte = word[15:8];
            default: sel_byte = word[7:0];
        endcase
    end

    assign sel_half = ofs[1] ? word[15:0] : word[31:16];

    // ---------------------------------------------------------------------------
    // Unaligned word merge
    // ---------------------------------------------------------------------------

    // Memory bytes k..3 go high, low k bytes kept from the register
    always_comb begin
        case (ofs)
            2'd0:    lwl_data = word;
            2'd1:    lwl_data = {word[23:0], req.reg_b[7:0]};
            2'd2:    lwl_data = {word[15:0], req.reg_b[15:0]};
            default: lwl_data = {word[7:0], req.reg_b[23:0]};
        endcase
    end

    // Memory bytes 0..k go low, high 3-k bytes kept from the register
    always_comb begin
        case (ofs)
            2'd0:    lwr_data = {req.reg_b[31:8], word[31:24]};
            2'd1:    lwr_data = {req.reg_b[31:16], word[31:16]};
            2'd2:    lwr_data = {req.reg_b[31:24], word[31:8]};
            default: lwr_data = word;
        endcase
    end

    // Fetch and LW take the word as is
    always_comb begin
        rdata = word;
        if (req.kind == ACC_LOAD) begin
            case (req.op)
                LB:      rdata = {{(`MEM_WORD_W-8){sel_byte[7]}}, sel_byte};
                LBU:     rdata = {{(`MEM_WORD_W-8){1'b0}}, sel_byte};
                LH:      rdata = {{(`MEM_WORD_W-16){sel_half[15]}}, sel_half};
                LHU:     rdata = {{(`MEM_WORD_W-16){1'b0}}, sel_half};
                LWL:     rdata = lwl_data;
                LWR:     rdata = lwr_data;
                default: rdata = word;
            endcase
        end
    end

endmodule

/* rtl/store_aligner.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module store_aligner (
    input  mem_bus_pkg::core_req_t  req,
    output logic [`MEM_WORD_W-1:0]  wdata,
    output logic [`MEM_STRB_W-1:0]  strb
);
    import mips_isa_pkg::*;

    logic [`MEM_OFS_W-1:0] ofs;
    logic [7:0]            src_byte;
    logic [15:0]           src_half;

    assign ofs      = req.addr[`MEM_OFS_W-1:0];
    assign src_byte = req.reg_b[7:0];
    assign src_half = req.reg_b[15:0];

    // ---------------------------------------------------------------------------
    // Lane placement and strobes
    // ---------------------------------------------------------------------------
    always_comb begin
        wdata = '0;
        strb  = '0;
        if (req.kind == ACC_STORE) begin
            case (req.op)
                SW: begin
                    wdata = req.reg_b;
                    strb  = 4'b1111;
                end
                SB: begin
                    // Same byte on every lane, strobe picks the one at offset k
                    wdata = {(`MEM_STRB_W){src_byte}};
                    strb  = 4'b1000 >> ofs;
                end
                SH: begin
                    if (!ofs[1]) begin
                        wdata = {src_half, 16'd0};
                        strb  = 4'b1100;
                    end else begin
                        wdata = {16'd0, src_half};
                        strb  = 4'b0011;
                    end
                end
                default: begin
                    wdata = '0;
                    strb  = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/apb_access_ctrl.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module apb_access_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  mem_bus_pkg::core_req_t  req,
    output mem_bus_pkg::core_req_t  cap_req,
    output logic [`MEM_WORD_W-1:0]  cap_word,
    input  logic [`MEM_WORD_W-1:0]  load_data,
    input  logic [`MEM_WORD_W-1:0]  store_data,
    input  logic [`MEM_STRB_W-1:0]  store_strb,
    output mem_bus_pkg::apb_req_t   apb,
    input  mem_bus_pkg::apb_resp_t  apb_rsp,
    output mem_bus_pkg::core_resp_t resp,
    output logic                    mem_halt
);
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;

    ctrl_state_t            state;
    ctrl_state_t            state_nxt;
    logic                   accept;
    logic                   xfer_end;
    logic                   is_write;
    logic                   done_q;
    logic [`MEM_WORD_W-1:0] rdata_q;

    // Only one transfer in flight, and none while the last is reported
    assign accept   = (state == ST_IDLE) && req_valid && !mem_halt;
    assign xfer_end = (state == ST_ACCESS) && apb_rsp.pready;
    assign is_write = (cap_req.kind == ACC_STORE);

    // ---------------------------------------------------------------------------
    // Transfer FSM
    // ---------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_SETUP;
                end
            end
            ST_SETUP: begin
                state_nxt = ST_ACCESS;
            end
            ST_ACCESS: begin
                if (apb_rsp.pready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            done_q   <= 1'b0;
            mem_halt <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_q <= xfer_end;
            // Halt covers the done cycle so a held req_valid is not taken twice
            if (accept) begin
                mem_halt <= 1'b1;
            end else if (done_q) begin
                mem_halt <= 1'b0;
            end
        end
    end

    // Request held for the aligners, keeps bus fields steady in wait states
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_req <= req;
        end
    end

    // Read word as sampled together with pready
    assign cap_word = apb_rsp.prdata;

    always_ff @(posedge clk) begin
        if (xfer_end) begin
            rdata_q <= load_data;
        end
    end

    // ---------------------------------------------------------------------------
    // Bus and core outputs
    // ---------------------------------------------------------------------------
    always_comb begin
        apb.psel    = (state != ST_IDLE);
        apb.penable = (state == ST_ACCESS);
        apb.pwrite  = is_write;
        apb.paddr   = {cap_req.addr[`MEM_WORD_W-1:`MEM_OFS_W], {(`MEM_OFS_W){1'b0}}};
        apb.pwdata  = store_data;
        // No strobes on reads
        apb.pstrb   = is_write ? store_strb : '0;
    end

    assign resp.done  = done_q;
    assign resp.rdata = rdata_q;

endmodule

/* rtl/mem_access_unit.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_access_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  mem_bus_pkg::core_req_t  req,
    output mem_bus_pkg::core_resp_t resp,
    output logic                    mem_halt,
    output mem_bus_pkg::apb_req_t   apb,
    input  mem_bus_pkg::apb_resp_t  apb_rsp
);
    import mem_bus_pkg::*;

    core_req_t              cap_req;
    logic [`MEM_WORD_W-1:0] cap_word;
    logic [`MEM_WORD_W-1:0] load_data;
    logic [`MEM_WORD_W-1:0] store_data;
    logic [`MEM_STRB_W-1:0] store_strb;

    // ---------------------------------------------------------------------------
    // Data path, both sides work from the captured request
    // ---------------------------------------------------------------------------
    load_aligner load_aligner_i (
        .req   (cap_req),
        .word  (cap_word),
        .rdata (load_data)
    );

    store_aligner store_aligner_i (
        .req   (cap_req),
        .wdata (store_data),
        .strb  (store_strb)
    );

    // Bus sequencing
    apb_access_ctrl apb_access_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .cap_req    (cap_req),
        .cap_word   (cap_word),
        .load_data  (load_data),
        .store_data (store_data),
        .store_strb (store_strb),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .resp       (resp),
        .mem_halt   (mem_halt)
    );

endmodule

/* verification/mem_access_unit_properties.sv */
`timescale 1ns/1ps

module mem_access_unit_properties (
    input logic                    clk,
    input logic                    rst_n,
    input mem_bus_pkg::apb_req_t   apb,
    input mem_bus_pkg::apb_resp_t  apb_rsp,
    input mem_bus_pkg::core_resp_t resp,
    input logic                    mem_halt
);
    // Number of failed properties
    int fail_cnt = 0;

    // ---------------------------------------------------------------------------
    // APB phases
    // ---------------------------------------------------------------------------
    a_setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
        apb.psel && !apb.penable |=> apb.psel && apb.penable)
        else begin
            fail_cnt++;
            $error("APB setup phase not followed by an access phase");
        end

    // Bus fields frozen during wait states
    a_stable_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        apb.psel && apb.penable && !apb_rsp.pready |=>
            apb.psel && apb.penable && $stable(apb.paddr) && $stable(apb.pwrite)
            && $stable(apb.pwdata) && $stable(apb.pstrb))
        else begin
            fail_cnt++;
            $error("APB request changed while pready was low");
        end

    // ---------------------------------------------------------------------------
    // Core response
    // ---------------------------------------------------------------------------
    a_done_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
        apb.psel && apb.penable && apb_rsp.pready |=> resp.done)
        else begin
            fail_cnt++;
            $error("done missing on the cycle after pready");
        end

    a_done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp.done |=> !resp.done)
        else begin
            fail_cnt++;
            $error("done held for more than one cycle");
        end

    a_halt_until_done: assert property (@(posedge clk) disable iff (!rst_n)
        mem_halt && !resp.done |=> mem_halt)
        else begin
            fail_cnt++;
            $error("mem_halt dropped before done");
        end

    a_halt_in_transfer: assert property (@(posedge clk) disable iff (!rst_n)
        apb.psel |-> mem_halt)
        else begin
            fail_cnt++;
            $error("APB transfer running while mem_halt is low");
        end

endmodule

/* verification/mem_access_unit_tb.sv */
`timescale 1ns/1ps
`include "mem_defs.svh"

module mem_access_unit_tb;
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;

    localparam int MEM_WORDS  = 64;
    localparam int WAIT_LIMIT = 20;
    localparam logic [31:0] SEED = 32'h22a8_4053;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    core_req_t  req;
    core_resp_t resp;
    logic       mem_halt;
    apb_req_t   apb;
    apb_resp_t  apb_rsp;

    logic [`MEM_WORD_W-1:0] mem [MEM_WORDS];
    logic [`MEM_WORD_W-1:0] shadow [MEM_WORDS];
    logic [31:0]            wait_rng;
    logic [31:0]            data_rng;
    int                     wait_left;
    logic [5:0]             mdl_idx;

    // Last completed transfer as seen by the memory
    logic                   seen_pwrite;
    logic [`MEM_STRB_W-1:0] seen_pstrb;
    logic [`MEM_WORD_W-1:0] seen_paddr;

    int errors = 0;
    int tests = 0;
    int failing = 0;

    mem_op_t sub_ops[4] = '{LB, LBU, LH, LHU};
    mem_op_t st_ops[3]  = '{SB, SH, SW};
    mem_op_t all_ops[10] = '{LB, LBU, LH, LHU, LW, LWL, LWR, SB, SH, SW};

    mem_access_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .resp      (resp),
        .mem_halt  (mem_halt),
        .apb       (apb),
        .apb_rsp   (apb_rsp)
    );

    bind apb_access_ctrl mem_access_unit_properties props_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb      (apb),
        .apb_rsp  (apb_rsp),
        .resp     (resp),
        .mem_halt (mem_halt)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Top bits of both halves set so sign extension shows
    function automatic logic [31:0] fill_word(input int i);
        return ((32'(i) * 32'h0103_0507) ^ 32'hc3a5_96f0) | 32'h8000_8000;
    endfunction

    function automatic logic [31:0] low_mask(input int nbytes);
        return 32'((64'h1 << (8 * nbytes)) - 64'h1);
    endfunction

    // ---------------------------------------------------------------------------
    // Reference rules
    // ---------------------------------------------------------------------------
    function automatic logic [31:0] load_expect(input mem_op_t op, input logic [31:0] w,
                                                input logic [1:0] k, input logic [31:0] rb);
        int          kk;
        logic [7:0]  b;
        logic [15:0] h;
        kk = int'(k);
        b  = w[31-8*kk -: 8];
        h  = w[31-16*int'(k[1]) -: 16];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            LWL:     return (w << (8 * kk)) | (rb & low_mask(kk));
            LWR:     return (w >> (8 * (3 - kk))) | (rb & ~low_mask(kk + 1));
            default: return w;
        endcase
    endfunction

    function automatic logic [3:0] strobe_expect(input mem_op_t op, input logic [1:0] k);
        case (op)
            SW:      return 4'b1111;
            SB:      return 4'b0001 << (3 - int'(k));
            SH:      return 4'b1100 >> (2 * int'(k[1]));
            default: return 4'b0000;
        endcase
    endfunction

    task automatic store_shadow(input mem_op_t op, input int i, input logic [1:0] k,
                                input logic [31:0] rb);
        case (op)
            SW: shadow[i] = rb;
            SB: shadow[i][31-8*int'(k) -: 8] = rb[7:0];
            SH: begin
                if (k[1]) begin
                    shadow[i][15:0] = rb[15:0];
                end else begin
                    shadow[i][31:16] = rb[15:0];
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ---------------------------------------------------------------------------
    // APB memory with random wait states
    // ---------------------------------------------------------------------------
    initial begin
        apb_rsp.pready = 1'b0;
        apb_rsp.prdata = '0;
        wait_rng       = SEED;
        wait_left      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(posedge clk);
            #1;
            wait_rng       = xorshift(wait_rng);
            apb_rsp.pready = 1'b0;
            // Junk on prdata outside the ready cycle
            apb_rsp.prdata = wait_rng;
            if (apb.psel && !apb.penable) begin
                wait_left = int'(wait_rng[1:0]);
            end else if (apb.psel && apb.penable) begin
                if (wait_left == 0) begin
                    mdl_idx        = apb.paddr[7:2];
                    apb_rsp.pready = 1'b1;
                    apb_rsp.prdata = mem[mdl_idx];
                    seen_pwrite    = apb.pwrite;
                    seen_pstrb     = apb.pstrb;
                    seen_paddr     = apb.paddr;
                    if (apb.pwrite) begin
                        for (int b = 0; b < 4; b++) begin
                            if (apb.pstrb[b]) begin
                                mem[mdl_idx][8*b +: 8] = apb.pwdata[8*b +: 8];
                            end
                        end
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Core side
    // ---------------------------------------------------------------------------
    task automatic do_access(input access_kind_t kind, input mem_op_t op,
                             input logic [31:0] addr, input logic [31:0] rb,
                             output logic [31:0] rdata);
        int n;
        req.kind  = kind;
        req.op    = op;
        req.addr  = addr;
        req.reg_b = rb;
        req_valid = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!resp.done && n < WAIT_LIMIT);
        if (!resp.done) begin
            $display("No done within %0d cycles for access at %h", WAIT_LIMIT, addr);
            $display("test failed");
            $finish;
        end else begin
            assert (n >= 3) else begin
                $display("Done arrived only %0d cycles after the request", n);
                errors++;
            end
            rdata     = resp.rdata;
            req_valid = 1'b0;
        end
    endtask

    task automatic run_checked(input access_kind_t kind, input mem_op_t op,
                               input logic [31:0] addr, input logic [31:0] rb);
        logic [31:0] got;
        logic [31:0] exp;
        logic [1:0]  k;
        int          i;
        k = addr[1:0];
        i = int'(addr[7:2]);
        do_access(kind, op, addr, rb, got);
        check_value("paddr", seen_paddr, {addr[31:2], 2'b00});
        if (kind == ACC_STORE) begin
            check_value("pwrite", 32'(seen_pwrite), 32'd1);
            check_value("pstrb", 32'(seen_pstrb), 32'(strobe_expect(op, k)));
            store_shadow(op, i, k, rb);
        end else begin
            check_value("pwrite", 32'(seen_pwrite), 32'd0);
            check_value("pstrb", 32'(seen_pstrb), 32'd0);
            exp = (kind == ACC_FETCH) ? shadow[i] : load_expect(op, shadow[i], k, rb);
            check_value("rdata", got, exp);
        end
    endtask

    task automatic check_idle_outputs();
        check_value("psel", 32'(apb.psel), 32'd0);
        check_value("penable", 32'(apb.penable), 32'd0);
        check_value("done", 32'(resp.done), 32'd0);
        check_value("mem_halt", 32'(mem_halt), 32'd0);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            failing++;
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    initial begin
        int           err_start;
        int           prop_fails;
        logic [31:0]  r;
        logic [31:0]  addr;
        mem_op_t      op;
        access_kind_t kind;

        rst_n     = 1'b0;
        req_valid = 1'b0;
        req.kind  = ACC_NONE;
        req.op    = LW;
        req.addr  = '0;
        req.reg_b = '0;
        data_rng  = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_word(i);
        end

        err_start = errors;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_idle_outputs();
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_idle_outputs();
        report_test("reset", err_start);

        err_start = errors;
        for (int i = 0; i < 4; i++) begin
            run_checked(ACC_FETCH, LW, 32'(4 * i), 32'd0);
            run_checked(ACC_LOAD, LW, 32'(16 + 4 * i), 32'd0);
        end
        report_test("fetch_lw", err_start);

        err_start = errors;
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 4; j++) begin
                run_checked(ACC_LOAD, sub_ops[j], 32'(32 + 4 * j + k), 32'hdead_beef);
            end
        end
        report_test("subword_loads", err_start);

        err_start = errors;
        for (int k = 0; k < 4; k++) begin
            for (int j = 0; j < 3; j++) begin
                data_rng = xorshift(data_rng);
                addr     = 32'(64 + 4 * j + k);
                run_checked(ACC_STORE, st_ops[j], addr, data_rng);
                run_checked(ACC_LOAD, LW, {addr[31:2], 2'b00}, 32'd0);
            end
        end
        report_test("stores", err_start);

        err_start = errors;
        for (int k = 0; k < 4; k++) begin
            data_rng = xorshift(data_rng);
            run_checked(ACC_LOAD, LWL, 32'(96 + k), data_rng);
            data_rng = xorshift(data_rng);
            run_checked(ACC_LOAD, LWR, 32'(100 + k), data_rng);
        end
        report_test("lwl_lwr", err_start);

        // Mixed traffic over the whole memory
        err_start = errors;
        for (int n = 0; n < 32; n++) begin
            data_rng = xorshift(data_rng);
            r        = data_rng;
            op       = all_ops[int'(r[15:8]) % 10];
            kind     = (op == SB || op == SH || op == SW) ? ACC_STORE : ACC_LOAD;
            addr     = {24'd0, r[29:24], r[1:0]};
            if (kind == ACC_LOAD && r[22:20] == 3'd0) begin
                kind = ACC_FETCH;
                addr = {24'd0, r[29:24], 2'b00};
            end
            run_checked(kind, op, addr, xorshift(r));
        end
        report_test("random_mix", err_start);

        prop_fails = dut_i.apb_access_ctrl_i.props_i.fail_cnt;
        errors += prop_fails;
        $display("%0d tests, %0d failing, %0d errors, %0d from bus properties",
                 tests, failing, errors, prop_fails);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+rtl
rtl/mips_isa_pkg.sv
rtl/mem_bus_pkg.sv
rtl/load_aligner.sv
rtl/store_aligner.sv
rtl/apb_access_ctrl.sv
rtl/mem_access_unit.sv
verification/mem_access_unit_properties.sv
verification/mem_access_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = mem_access_unit_tb
FILELIST  = build.f
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+1000

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
